/* common/vm16_pkg.sv */
// Shared definitions for the vm16 CPU: ISA encodings, ALU codes, address map and bus structs.
// RTL files refer to these by scoped name.
`default_nettype none

package vm16_pkg;

    localparam int data_w        = 16;
    localparam int reg_sel_w     = 3;
    localparam int imem_depth    = 64;
    localparam int scratch_depth = 64;
    localparam int imem_aw       = $clog2(imem_depth);
    localparam int scratch_aw    = $clog2(scratch_depth);

    // last instruction word, where the pc saturates
    localparam logic [data_w-1:0] pc_last = data_w'(imem_depth - 1);

    // scratch window; everything outside goes to APB
    localparam logic [data_w-1:0] scratch_base = 16'h0000;
    localparam logic [data_w-1:0] scratch_last = 16'h003F;

    // opcodes, instr[15:11]
    localparam logic [4:0] op_nop     = 5'h00;
    localparam logic [4:0] op_lw      = 5'h01;
    localparam logic [4:0] op_sw      = 5'h02;
    localparam logic [4:0] op_bit     = 5'h03;
    localparam logic [4:0] op_mov     = 5'h04;
    localparam logic [4:0] op_movi    = 5'h05;
    localparam logic [4:0] op_arith_u = 5'h06;
    localparam logic [4:0] op_arith_s = 5'h07;
    localparam logic [4:0] op_br      = 5'h08;
    localparam logic [4:0] op_cmp     = 5'h0A;
    localparam logic [4:0] op_setc    = 5'h0B;
    localparam logic [4:0] op_halt    = 5'h0C;

    // sub-functions in simm5 of the bit and arith groups
    localparam logic [4:0] bit_or     = 5'h00;
    localparam logic [4:0] bit_xor    = 5'h01;
    localparam logic [4:0] bit_and    = 5'h02;
    localparam logic [4:0] bit_not    = 5'h03;
    localparam logic [4:0] bit_lshft  = 5'h04;
    localparam logic [4:0] bit_rshft  = 5'h05;
    localparam logic [4:0] arith_add  = 5'b11111;
    localparam logic [4:0] arith_sub  = 5'b10000;
    // only bit 4 matters, the low four bits carry imm4
    localparam logic [4:0] arith_addi = 5'b00000;

    localparam logic [4:0] alu_nop   = 5'h00;
    localparam logic [4:0] alu_mov   = 5'h01;
    localparam logic [4:0] alu_add   = 5'h02;
    localparam logic [4:0] alu_sub   = 5'h03;
    localparam logic [4:0] alu_or    = 5'h04;
    localparam logic [4:0] alu_xor   = 5'h05;
    localparam logic [4:0] alu_and   = 5'h06;
    localparam logic [4:0] alu_not   = 5'h07;
    localparam logic [4:0] alu_lshft = 5'h08;
    localparam logic [4:0] alu_rshft = 5'h09;
    localparam logic [4:0] alu_cmp   = 5'h0A;
    localparam logic [4:0] alu_setc  = 5'h0B;

    // conditions for BR and SETC
    localparam logic [7:0] cond_always = 8'h00;
    localparam logic [7:0] cond_eq     = 8'h01;
    localparam logic [7:0] cond_ne     = 8'h02;
    localparam logic [7:0] cond_gt     = 8'h03;
    localparam logic [7:0] cond_lt     = 8'h04;
    localparam logic [7:0] cond_ge     = 8'h05;
    localparam logic [7:0] cond_le     = 8'h06;

    localparam int flag_n = 3;
    localparam int flag_z = 2;
    localparam int flag_c = 1;
    localparam int flag_v = 0;

    typedef struct packed {
        logic [4:0]           opcode;
        logic [reg_sel_w-1:0] rd;
        logic [reg_sel_w-1:0] ra;
        logic [4:0]           simm5;
    } instr_reg_t;

    typedef struct packed {
        logic [4:0]           opcode;
        logic [reg_sel_w-1:0] rd;
        logic [7:0]           imm8;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t reg_form;
        instr_imm_t imm_form;
    } instr_t;

    typedef struct packed {
        logic [4:0] alu_op;
        logic       has_imm4;
        logic       has_imm8;
        logic       has_we;
        logic       has_br;
        logic       has_mem;
        logic       has_mem_we;
        logic       has_cmp;
        logic       halt;
    } dec_t;

    typedef struct packed {
        logic              valid;
        logic              we;
        logic [data_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic              done;
        logic [data_w-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic [data_w-1:0] paddr;
        logic              pwrite;
        logic              psel;
        logic              penable;
        logic [data_w-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [data_w-1:0] prdata;
        logic              pready;
    } apb_rsp_t;

    typedef struct packed {
        logic               we;
        logic [imem_aw-1:0] addr;
        logic [data_w-1:0]  data;
    } prog_load_t;

endpackage

`default_nettype wire

/* verilog/vm16_mem.sv */
// Single-port synchronous memory; a write wins over the read in the same cycle.
// Used for instruction memory and for the scratch memory.
`timescale 1ns/1ps
`default_nettype none

module vm16_mem #(
    parameter int depth = 64
) (
    input  logic                        clk,
    input  logic [$clog2(depth)-1:0]    addr,
    input  logic [vm16_pkg::data_w-1:0] wdata,
    input  logic                        we,
    output logic [vm16_pkg::data_w-1:0] rdata
);
    logic [vm16_pkg::data_w-1:0] mem [depth];

    // write-first, a write shows the new word on rdata
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
            rdata     <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* core/vm16_regfile.sv */
// Eight general registers, one asynchronous read port and one write port.
`timescale 1ns/1ps
`default_nettype none

module vm16_regfile (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [vm16_pkg::reg_sel_w-1:0] rs,
    output logic [vm16_pkg::data_w-1:0]    rd,
    input  logic                           we,
    input  logic [vm16_pkg::reg_sel_w-1:0] ws,
    input  logic [vm16_pkg::data_w-1:0]    wd
);
    logic [vm16_pkg::data_w-1:0] regs [2**vm16_pkg::reg_sel_w];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**vm16_pkg::reg_sel_w; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[ws] <= wd;
        end
    end

    assign rd = regs[rs];

endmodule

`default_nettype wire

/* core/vm16_alu.sv */
// Combinational ALU with compare flags and the condition test shared by BR and SETC.
`timescale 1ns/1ps
`default_nettype none

module vm16_alu (
    input  logic [4:0]                  alu_op,
    input  logic [vm16_pkg::data_w-1:0] a,
    input  logic [vm16_pkg::data_w-1:0] b,
    input  logic [3:0]                  flags,
    output logic [vm16_pkg::data_w-1:0] c,
    output logic                        branch_ok
);
    logic [vm16_pkg::data_w:0] diff;
    logic [3:0]                cmp_flags;

    // sign-extended 17-bit subtract, shared by sub and cmp
    assign diff = {a[vm16_pkg::data_w-1], a} - {b[vm16_pkg::data_w-1], b};

    always_comb begin
        cmp_flags                   = '0;
        cmp_flags[vm16_pkg::flag_n] = diff[vm16_pkg::data_w-1];
        cmp_flags[vm16_pkg::flag_z] = (diff[vm16_pkg::data_w-1:0] == '0);
        cmp_flags[vm16_pkg::flag_c] = 1'b0;
        cmp_flags[vm16_pkg::flag_v] = diff[vm16_pkg::data_w] ^ diff[vm16_pkg::data_w-1];
    end

    // condition code sits in b's low byte
    always_comb begin
        case (b[7:0])
            vm16_pkg::cond_always: branch_ok = 1'b1;
            vm16_pkg::cond_eq:     branch_ok = flags[vm16_pkg::flag_z];
            vm16_pkg::cond_ne:     branch_ok = !flags[vm16_pkg::flag_z];
            vm16_pkg::cond_gt:     branch_ok = !flags[vm16_pkg::flag_z]
                                   && (flags[vm16_pkg::flag_n] == flags[vm16_pkg::flag_v]);
            vm16_pkg::cond_lt:     branch_ok = flags[vm16_pkg::flag_n] != flags[vm16_pkg::flag_v];
            vm16_pkg::cond_ge:     branch_ok = flags[vm16_pkg::flag_n] == flags[vm16_pkg::flag_v];
            vm16_pkg::cond_le:     branch_ok = flags[vm16_pkg::flag_z]
                                   || (flags[vm16_pkg::flag_n] != flags[vm16_pkg::flag_v]);
            default:               branch_ok = 1'b0;
        endcase
    end

    always_comb begin
        case (alu_op)
            vm16_pkg::alu_nop:   c = '0;
            vm16_pkg::alu_mov:   c = b;
            vm16_pkg::alu_add:   c = a + b;
            vm16_pkg::alu_sub:   c = diff[vm16_pkg::data_w-1:0];
            vm16_pkg::alu_or:    c = a | b;
            vm16_pkg::alu_xor:   c = a ^ b;
            vm16_pkg::alu_and:   c = a & b;
            vm16_pkg::alu_not:   c = ~b;
            vm16_pkg::alu_lshft: c = a << b;
            vm16_pkg::alu_rshft: c = a >> b;
            // flags land in the low nibble, stored by writeback
            vm16_pkg::alu_cmp:   c = {{(vm16_pkg::data_w-4){1'b0}}, cmp_flags};
            vm16_pkg::alu_setc:  c = {{(vm16_pkg::data_w-1){1'b0}}, branch_ok};
            default:             c = '0;
        endcase
    end

endmodule

`default_nettype wire

/* core/vm16_decoder.sv */
// Instruction decoder: opcode and sub-function to ALU code and datapath controls.
`timescale 1ns/1ps
`default_nettype none

module vm16_decoder (
    input  vm16_pkg::instr_t instr,
    output vm16_pkg::dec_t   dec
);
    logic [4:0] sub;

    assign sub = instr.reg_form.simm5;

    always_comb begin
        dec        = '0;
        dec.alu_op = vm16_pkg::alu_nop;
        case (instr.reg_form.opcode)
            vm16_pkg::op_nop, vm16_pkg::op_halt: begin
                dec.halt = (instr.reg_form.opcode == vm16_pkg::op_halt);
            end
            vm16_pkg::op_lw: begin
                dec.alu_op  = vm16_pkg::alu_mov;
                dec.has_mem = 1'b1;
                dec.has_we  = 1'b1;
            end
            vm16_pkg::op_sw: begin
                dec.alu_op     = vm16_pkg::alu_mov;
                dec.has_mem    = 1'b1;
                dec.has_mem_we = 1'b1;
            end
            vm16_pkg::op_mov: begin
                dec.alu_op = vm16_pkg::alu_mov;
                dec.has_we = 1'b1;
            end
            vm16_pkg::op_movi: begin
                dec.alu_op   = vm16_pkg::alu_mov;
                dec.has_imm8 = 1'b1;
                dec.has_we   = 1'b1;
            end
            // target in rd, condition in imm8
            vm16_pkg::op_br: begin
                dec.has_br   = 1'b1;
                dec.has_imm8 = 1'b1;
            end
            vm16_pkg::op_cmp: begin
                dec.alu_op  = vm16_pkg::alu_cmp;
                dec.has_cmp = 1'b1;
            end
            vm16_pkg::op_setc: begin
                dec.alu_op = vm16_pkg::alu_setc;
                dec.has_we = 1'b1;
            end
            vm16_pkg::op_bit: begin
                dec.has_we = 1'b1;
                case (sub)
                    vm16_pkg::bit_or:    dec.alu_op = vm16_pkg::alu_or;
                    vm16_pkg::bit_xor:   dec.alu_op = vm16_pkg::alu_xor;
                    vm16_pkg::bit_and:   dec.alu_op = vm16_pkg::alu_and;
                    vm16_pkg::bit_not:   dec.alu_op = vm16_pkg::alu_not;
                    vm16_pkg::bit_lshft: dec.alu_op = vm16_pkg::alu_lshft;
                    vm16_pkg::bit_rshft: dec.alu_op = vm16_pkg::alu_rshft;
                    default:             dec.has_we = 1'b0;
                endcase
            end
            // signed and unsigned forms give the same 16-bit result
            vm16_pkg::op_arith_u, vm16_pkg::op_arith_s: begin
                dec.has_we = 1'b1;
                if (sub == vm16_pkg::arith_add) begin
                    dec.alu_op = vm16_pkg::alu_add;
                end else if (sub == vm16_pkg::arith_sub) begin
                    dec.alu_op = vm16_pkg::alu_sub;
                end else if (sub[4] == vm16_pkg::arith_addi[4]) begin
                    dec.alu_op   = vm16_pkg::alu_add;
                    dec.has_imm4 = 1'b1;
                end else begin
                    dec.has_we = 1'b0;
                end
            end
            default: dec.alu_op = vm16_pkg::alu_nop;
        endcase
    end

endmodule

`default_nettype wire

/* core/vm16_core.sv */
// Multi-cycle vm16 core: fetch, decode, two register reads, optional memory access, writeback.
// Loads and stores leave through the mem_req/mem_rsp pair to the MMU.
`timescale 1ns/1ps
`default_nettype none

module vm16_core (
    input  logic                 clk,
    input  logic                 reset,
    input  vm16_pkg::prog_load_t prog,
    output vm16_pkg::mem_req_t   req,
    input  vm16_pkg::mem_rsp_t   rsp,
    output logic                 halted
);
    typedef enum logic [2:0] {
        st_fetch, st_decode, st_read_a, st_read_b, st_mem, st_writeback, st_halted
    } state_t;

    state_t                            state;
    logic [vm16_pkg::data_w-1:0]       pc;
    vm16_pkg::instr_t                  instr;
    vm16_pkg::dec_t                    dec;
    logic [vm16_pkg::imem_aw-1:0]      imem_addr;
    logic [vm16_pkg::data_w-1:0]       imem_rdata;
    logic [vm16_pkg::reg_sel_w-1:0]    rf_rs;
    logic [vm16_pkg::data_w-1:0]       rf_rdata;
    logic [vm16_pkg::data_w-1:0]       rf_wdata;
    logic                              rf_we;
    logic [vm16_pkg::data_w-1:0]       rdd;
    logic [vm16_pkg::data_w-1:0]       rda;
    logic [3:0]                        flags;
    logic [vm16_pkg::data_w-1:0]       alu_c;
    logic                              branch_ok;
    logic [vm16_pkg::data_w-1:0]       imm8_ext;
    logic [vm16_pkg::data_w-1:0]       imm4_ext;
    logic [vm16_pkg::data_w-1:0]       simm5_ext;
    logic                              req_valid;
    logic                              pending;

    // program load owns the port while it writes
    assign imem_addr = prog.we ? prog.addr : pc[vm16_pkg::imem_aw-1:0];

    assign imm8_ext  = {{(vm16_pkg::data_w-8){1'b0}}, instr.imm_form.imm8};
    assign imm4_ext  = {{(vm16_pkg::data_w-4){1'b0}}, instr.reg_form.simm5[3:0]};
    assign simm5_ext = {{(vm16_pkg::data_w-5){instr.reg_form.simm5[4]}}, instr.reg_form.simm5};

    // rd in the first read cycle, ra in the second
    assign rf_rs    = (state == st_read_b) ? instr.reg_form.ra : instr.reg_form.rd;
    assign rf_we    = dec.has_we && (state == st_writeback);
    assign rf_wdata = dec.has_mem ? rsp.rdata : alu_c;

    // addr, we and wdata hold while in st_mem since rdd, rda and instr do
    assign req = '{valid: req_valid, we: dec.has_mem_we, addr: alu_c + simm5_ext, wdata: rdd};

    assign halted = (state == st_halted);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_fetch;
            pc        <= '0;
            flags     <= '0;
            req_valid <= 1'b0;
        end else begin
            req_valid <= 1'b0;
            case (state)
                st_fetch: state <= st_decode;
                st_decode: begin
                    instr <= imem_rdata;
                    state <= st_read_a;
                end
                st_read_a: begin
                    rdd   <= rf_rdata;
                    state <= dec.halt ? st_halted : st_read_b;
                end
                st_read_b: begin
                    if (dec.has_imm8) begin
                        rda <= imm8_ext;
                    end else if (dec.has_imm4) begin
                        rda <= rf_rdata + imm4_ext;
                    end else begin
                        rda <= rf_rdata;
                    end
                    if (dec.has_mem) begin
                        req_valid <= 1'b1;
                        state     <= st_mem;
                    end else begin
                        state <= st_writeback;
                    end
                end
                st_mem: begin
                    if (rsp.done) begin
                        state <= st_writeback;
                    end
                end
                st_writeback: begin
                    if (dec.has_cmp) begin
                        flags <= alu_c[3:0];
                    end
                    if (dec.has_br && branch_ok) begin
                        pc <= rdd;
                    end else if (pc < vm16_pkg::pc_last) begin
                        pc <= pc + 1'b1;
                    end
                    state <= st_fetch;
                end
                st_halted: state <= st_halted;
                default:   state <= st_fetch;
            endcase
        end
    end

    // request outstanding from valid until the MMU answers
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (req_valid) begin
            pending <= 1'b1;
        end else if (rsp.done) begin
            pending <= 1'b0;
        end
    end

    a_one_request: assert property (@(posedge clk) disable iff (reset) req_valid |-> !pending);

    vm16_mem #(.depth(vm16_pkg::imem_depth)) u_imem (
        .clk   (clk),
        .addr  (imem_addr),
        .wdata (prog.data),
        .we    (prog.we),
        .rdata (imem_rdata)
    );

    vm16_decoder u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    vm16_regfile u_regfile (
        .clk   (clk),
        .reset (reset),
        .rs    (rf_rs),
        .rd    (rf_rdata),
        .we    (rf_we),
        .ws    (instr.reg_form.rd),
        .wd    (rf_wdata)
    );

    vm16_alu u_alu (
        .alu_op    (dec.alu_op),
        .a         (rdd),
        .b         (rda),
        .flags     (flags),
        .c         (alu_c),
        .branch_ok (branch_ok)
    );

endmodule

`default_nettype wire

/* mmu/vm16_mmu.sv */
// Memory-management unit: scratch window to the local memory, all else to the APB master.
// Answers each core request with a single done pulse and registered read data.
`timescale 1ns/1ps
`default_nettype none

module vm16_mmu (
    input  logic               clk,
    input  logic               reset,
    input  vm16_pkg::mem_req_t req,
    output vm16_pkg::mem_rsp_t rsp,
    output vm16_pkg::apb_req_t apb_out,
    input  vm16_pkg::apb_rsp_t apb_in
);
    typedef enum logic [1:0] {st_idle, st_setup, st_access} apb_state_t;

    apb_state_t                  state;
    logic [vm16_pkg::data_w-1:0] offset;
    logic                        in_scratch;
    logic                        scratch_we;
    logic                        scratch_pend;
    logic [vm16_pkg::data_w-1:0] scratch_rdata;

    // below the base the offset wraps high and misses the window
    assign offset     = req.addr - vm16_pkg::scratch_base;
    assign in_scratch = offset <= (vm16_pkg::scratch_last - vm16_pkg::scratch_base);
    assign scratch_we = req.valid && req.we && in_scratch;

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= st_idle;
            apb_out.psel    <= 1'b0;
            apb_out.penable <= 1'b0;
            rsp.done        <= 1'b0;
            scratch_pend    <= 1'b0;
        end else begin
            rsp.done     <= 1'b0;
            scratch_pend <= req.valid && in_scratch;
            // scratch read data is out one cycle after valid
            if (scratch_pend) begin
                rsp.done  <= 1'b1;
                rsp.rdata <= scratch_rdata;
            end
            case (state)
                st_idle: begin
                    if (req.valid && !in_scratch) begin
                        apb_out.paddr  <= req.addr;
                        apb_out.pwrite <= req.we;
                        apb_out.pwdata <= req.wdata;
                        apb_out.psel   <= 1'b1;
                        state          <= st_setup;
                    end
                end
                st_setup: begin
                    apb_out.penable <= 1'b1;
                    state           <= st_access;
                end
                st_access: begin
                    // wait states while pready is low
                    if (apb_in.pready) begin
                        apb_out.psel    <= 1'b0;
                        apb_out.penable <= 1'b0;
                        rsp.rdata       <= apb_in.prdata;
                        rsp.done        <= 1'b1;
                        state           <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    a_paddr_stable: assert property (@(posedge clk) disable iff (reset)
        apb_out.psel && $past(apb_out.psel) |-> $stable(apb_out.paddr));

    vm16_mem #(.depth(vm16_pkg::scratch_depth)) u_scratch (
        .clk   (clk),
        .addr  (offset[vm16_pkg::scratch_aw-1:0]),
        .wdata (req.wdata),
        .we    (scratch_we),
        .rdata (scratch_rdata)
    );

endmodule

`default_nettype wire

/* verilog/vm16_cpu.sv */
// vm16 CPU top: one core and its MMU, with the program load port and the APB master.
`timescale 1ns/1ps
`default_nettype none

module vm16_cpu (
    input  logic                 clk,
    input  logic                 reset,
    input  vm16_pkg::prog_load_t prog,
    output vm16_pkg::apb_req_t   apb_out,
    input  vm16_pkg::apb_rsp_t   apb_in,
    output logic                 halted
);
    vm16_pkg::mem_req_t mem_req;
    vm16_pkg::mem_rsp_t mem_rsp;

    vm16_core u_core (
        .clk    (clk),
        .reset  (reset),
        .prog   (prog),
        .req    (mem_req),
        .rsp    (mem_rsp),
        .halted (halted)
    );

    vm16_mmu u_mmu (
        .clk     (clk),
        .reset   (reset),
        .req     (mem_req),
        .rsp     (mem_rsp),
        .apb_out (apb_out),
        .apb_in  (apb_in)
    );

endmodule

`default_nettype wire

/* tb/vm16_tb.sv */
// Testbench for the vm16 CPU: loads the program from the stim file during reset, models an
// APB slave with random wait states, checks each APB write in order and the final halt.
`timescale 1ns/1ps
`default_nettype none

module vm16_tb;
    localparam int clk_half   = 2;
    localparam int stim_words = 256;
    localparam int quiet_wait = 50;

    logic                 clk = 1'b0;
    logic                 reset;
    vm16_pkg::prog_load_t prog;
    vm16_pkg::apb_req_t   apb_out;
    vm16_pkg::apb_rsp_t   apb_in = '0;
    logic                 halted;

    logic [15:0] stim [stim_words];
    // sparse slave memory, missing entries read as zero
    logic [15:0] slave_mem [logic [15:0]];
    int          prog_len;
    int          write_count;
    int          writes_seen = 0;
    int          wait_left;
    int          wait_pick;
    bit          loaded = 1'b0;

    always #clk_half clk = ~clk;

    vm16_cpu u_vm16_cpu (
        .clk     (clk),
        .reset   (reset),
        .prog    (prog),
        .apb_out (apb_out),
        .apb_in  (apb_in),
        .halted  (halted)
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
            fail_run("stopping at the first mismatch");
        end
    endtask

    function automatic logic [15:0] slave_read(input logic [15:0] addr);
        if (slave_mem.exists(addr)) begin
            return slave_mem[addr];
        end
        return 16'h0000;
    endfunction

    // compare one completed write with the next expected pair, then store it
    task automatic record_write(input logic [15:0] addr, input logic [15:0] data);
        int base;
        base = prog_len + 2 + 2 * writes_seen;
        if (writes_seen >= write_count) begin
            fail_run("APB write seen after all expected writes were done");
        end else begin
            check_value("paddr", addr, stim[base]);
            check_value("pwdata", data, stim[base + 1]);
            slave_mem[addr] = data;
            writes_seen++;
        end
    endtask

    // APB slave, 0 to 3 wait states per access
    always @(posedge clk) begin
        if (reset) begin
            apb_in.pready <= 1'b0;
            wait_left     <= 0;
        end else if (apb_out.psel && !apb_out.penable) begin
            // scratch addresses 0x0000 to 0x003F never reach the bus
            if (apb_out.paddr <= 16'h003F) begin
                fail_run("APB transfer started for an address in the scratch window");
            end
            wait_pick = int'($urandom % 4);
            wait_left     <= wait_pick;
            apb_in.pready <= (wait_pick == 0);
            apb_in.prdata <= slave_read(apb_out.paddr);
        end else if (apb_out.psel && apb_out.penable) begin
            if (apb_in.pready) begin
                apb_in.pready <= 1'b0;
                if (apb_out.pwrite) begin
                    record_write(apb_out.paddr, apb_out.pwdata);
                end
            end else begin
                if (wait_left == 1) begin
                    apb_in.pready <= 1'b1;
                end
                wait_left <= wait_left - 1;
            end
        end
    end

    // budget scales with program length and write count
    initial begin
        wait (loaded);
        repeat ((prog_len + write_count) * 40) @(posedge clk);
        fail_run("timeout: the CPU did not halt within the cycle budget");
    end

    initial begin
        void'($urandom(32'h9a7b));
        reset = 1'b1;
        prog  = '0;
        $readmemh("tb/vm16_stim.hex", stim);
        prog_len = int'(stim[0]);
        if (prog_len < 1 || prog_len > vm16_pkg::imem_depth) begin
            fail_run("stim file is missing or has a bad program length");
        end
        write_count = int'(stim[prog_len + 1]);
        loaded      = 1'b1;

        // reset spans the program load and then 5 more cycles
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            prog.we   <= 1'b1;
            prog.addr <= i[vm16_pkg::imem_aw-1:0];
            prog.data <= stim[i + 1];
        end
        @(posedge clk);
        prog <= '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        while (!halted) begin
            @(posedge clk);
        end

        // bus must stay idle once halted
        repeat (quiet_wait) begin
            @(posedge clk);
            check_value("halted", 16'(halted), 16'h0001);
            check_value("psel", 16'(apb_out.psel), 16'h0000);
        end
        check_value("apb write count", 16'(writes_seen), 16'(write_count));
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/vm16_stim.hex */
// word 0: program length N, then N instruction words, then the write count M,
// then M lines of expected APB writes, each as paddr pwdata
002F
// program: MOVI, SW, ADD, SUB, ADDI, bit and shift ops
2F80 295A 11E0 2A33 315F 11E1 3A30 12E2
3105 2B0F 1962 1941 2C04 1984 11E3 1985
// CMP and BR taken to 25, then CMP and BR not taken
1960 1D63 31BF 11E4 5380 2E19 4603 29EE
11E5 29AA 11E5 5460 2E1F 4601 2955 11E6
// SETC, scratch store and load, APB load, negative offset, HALT
5980 2D01 5AA0 11E7 12E8 2BC3 2E20 13C2
0DC2 15E9 0CE1 3401 14EA 16F0 6000
// expected APB writes
000C
0080 005A
0081 008D
0082 FFA6
0083 FA40
0084 0F9F
0085 00AA
0086 0055
0087 0001
0088 0000
0089 00C3
008A 008E
0070 0020

/* sources.f */
common/vm16_pkg.sv
verilog/vm16_mem.sv
core/vm16_regfile.sv
core/vm16_alu.sv
core/vm16_decoder.sv
core/vm16_core.sv
mmu/vm16_mmu.sv
verilog/vm16_cpu.sv
tb/vm16_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the vm16 testbench with Verilator, run it, and look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f sources.f --top-module vm16_tb -o vm16_sim \
    > build.log 2>&1 \
    && ./obj_dir/vm16_sim > sim.log 2>&1
grep -q "^TEST RESULT: PASS$" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
